// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= flash_boot_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+source
source/flash_boot_pkg.sv
source/spi_flash_reader.sv
source/boot_loader.sv
source/boot_rom.sv
source/uart_tx.sv
source/flash_boot_top.sv
testbench/flash_boot_properties.sv
testbench/flash_boot_tb.sv

// ==== source/boot_loader.sv ====
`timescale 1ns/1ns
`include "flash_boot_consts.svh"

module boot_loader (
  input  logic                      CLK,
  input  logic                      rst,
  input  logic                      byte_valid,
  input  logic [7:0]                byte_data,
  input  logic [15:0]               rom_rdata,
  input  logic                      tx_ready,
  output logic                      byte_request,
  output logic                      read_done,
  output logic                      rom_we,
  output flash_boot_pkg::rom_addr_t rom_addr,
  output logic [15:0]               rom_wdata,
  output logic                      tx_valid,
  output logic [7:0]                tx_byte
);

  localparam logic [2:0] ST_LOAD     = 3'd0;
  localparam logic [2:0] ST_DUMP_RD  = 3'd1;
  localparam logic [2:0] ST_DUMP_CAP = 3'd2;
  localparam logic [2:0] ST_SEND_HI  = 3'd3;
  localparam logic [2:0] ST_SEND_LO  = 3'd4;
  localparam logic [2:0] ST_DONE     = 3'd5;

  logic [2:0]                  state;
  logic                        hi_next;
  logic                        last_addr;
  flash_boot_pkg::flash_word_u load_word;
  flash_boot_pkg::flash_word_u dump_word;

  assign last_addr = (rom_addr == flash_boot_pkg::rom_addr_t'(`BOOT_WORDS - 1));
  // Word assembled by byte, stored whole
  assign rom_wdata = load_word.word;

  ////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Big-endian pairing
    if (state == ST_LOAD && byte_valid) begin
      if (hi_next) begin
        load_word.bytes.hi <= byte_data;
      end else begin
        load_word.bytes.lo <= byte_data;
      end
    end
    // Registered ROM data lands here
    if (state == ST_DUMP_CAP) begin
      dump_word.word <= rom_rdata;
    end
    // Byte offered to the UART, held until accepted
    if (state == ST_SEND_HI && !tx_valid) begin
      tx_byte <= dump_word.bytes.hi;
    end else if (state == ST_SEND_LO && !tx_valid) begin
      tx_byte <= dump_word.bytes.lo;
    end
  end

  ////////////////////////////////////////////////////////////
  // Load and dump FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      state        <= ST_LOAD;
      hi_next      <= 1'b1;
      rom_addr     <= '0;
      rom_we       <= 1'b0;
      byte_request <= 1'b0;
      read_done    <= 1'b0;
      tx_valid     <= 1'b0;
    end else begin
      rom_we       <= 1'b0;
      byte_request <= 1'b0;
      read_done    <= 1'b0;
      case (state)
        ST_LOAD: begin
          if (byte_valid) begin
            hi_next <= ~hi_next;
            if (hi_next) begin
              byte_request <= 1'b1;
            end else begin
              // Pair complete, write next cycle
              rom_we <= 1'b1;
              if (last_addr) begin
                read_done <= 1'b1;
              end else begin
                byte_request <= 1'b1;
              end
            end
          end
          // Advance after the write cycle
          if (rom_we) begin
            if (last_addr) begin
              rom_addr <= '0;
              state    <= ST_DUMP_RD;
            end else begin
              rom_addr <= rom_addr + 1'b1;
            end
          end
        end
        // Address presented, data next cycle
        ST_DUMP_RD: state <= ST_DUMP_CAP;
        ST_DUMP_CAP: state <= ST_SEND_HI;
        ST_SEND_HI: begin
          if (!tx_valid) begin
            tx_valid <= 1'b1;
          end else if (tx_ready) begin
            tx_valid <= 1'b0;
            state    <= ST_SEND_LO;
          end
        end
        ST_SEND_LO: begin
          if (!tx_valid) begin
            tx_valid <= 1'b1;
          end else if (tx_ready) begin
            tx_valid <= 1'b0;
            if (last_addr) begin
              state <= ST_DONE;
            end else begin
              rom_addr <= rom_addr + 1'b1;
              state    <= ST_DUMP_RD;
            end
          end
        end
        ST_DONE: state <= ST_DONE;
        default: state <= ST_DONE;
      endcase
    end
  end

endmodule

// ==== source/boot_rom.sv ====
`timescale 1ns/1ns
`include "flash_boot_consts.svh"

module boot_rom (
  input  logic                      CLK,
  input  logic                      we,
  input  flash_boot_pkg::rom_addr_t addr,
  input  logic [15:0]               wdata,
  output logic [15:0]               rdata
);

  localparam int DEPTH = 2 ** `BOOT_ADDR_W;

  // Boot image storage
  logic [15:0] mem [0:DEPTH-1];

  // Single port, one access per cycle
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= wdata;
      // Write-first, new word shows on the read port
      rdata <= wdata;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

// ==== source/flash_boot_consts.svh ====
`ifndef FLASH_BOOT_CONSTS_SVH
`define FLASH_BOOT_CONSTS_SVH

////////////////////////////////////////////////////////////
// SPI flash commands
////////////////////////////////////////////////////////////

// Reset enable, sent alone in its own select
`define FLASH_RESET_CMD_1 8'h66
// Reset device, second select
`define FLASH_RESET_CMD_2 8'h99
// Plain read with 24-bit address
`define FLASH_READ_CMD 8'h03
// Boot image start inside the flash
`define FLASH_READ_OFFSET 24'h100000

// Idle cycles while the flash recovers from reset
`define FLASH_RESET_WAIT 400
// System clocks per SCK half-period
`define FLASH_SCK_HALF 8

////////////////////////////////////////////////////////////
// Boot image and serial port
////////////////////////////////////////////////////////////

`define BOOT_WORDS 16
// Keep in step with BOOT_WORDS
`define BOOT_ADDR_W 4
`define UART_CLKS_PER_BIT 16

`endif

// ==== source/flash_boot_pkg.sv ====
`include "flash_boot_consts.svh"

package flash_boot_pkg;

  // One flash word seen two ways
  // Bytes arrive big-endian, so hi comes first on the wire
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } bytes;
  } flash_word_u;

  // Boot ROM word address
  typedef logic [`BOOT_ADDR_W-1:0] rom_addr_t;

endpackage

// ==== source/flash_boot_top.sv ====
`timescale 1ns/1ns

module flash_boot_top (
  input  logic CLK,
  input  logic rst,
  input  logic flash_miso,
  output logic flash_sck,
  output logic flash_ssb,
  output logic flash_mosi,
  output logic flash_wp_n,
  output logic flash_hold_n,
  output logic tx
);

  // Reader to loader
  logic [7:0] byte_data;
  logic       byte_valid;
  logic       byte_request;
  logic       read_done;

  // Loader to ROM
  logic                      rom_we;
  flash_boot_pkg::rom_addr_t rom_addr;
  logic [15:0]               rom_wdata;
  logic [15:0]               rom_rdata;

  // Loader to UART
  logic [7:0] tx_byte;
  logic       tx_valid;
  logic       tx_ready;

  // Write protect and hold unused
  assign flash_wp_n   = 1'b1;
  assign flash_hold_n = 1'b1;

  ////////////////////////////////////////////////////////////
  // Input side, processing, output side
  ////////////////////////////////////////////////////////////

  spi_flash_reader reader0 (
    .CLK(CLK), .rst(rst), .flash_miso(flash_miso),
    .byte_request(byte_request), .read_done(read_done),
    .flash_sck(flash_sck), .flash_ssb(flash_ssb), .flash_mosi(flash_mosi),
    .byte_valid(byte_valid), .byte_data(byte_data)
  );

  boot_loader loader0 (
    .CLK(CLK), .rst(rst), .byte_valid(byte_valid), .byte_data(byte_data),
    .rom_rdata(rom_rdata), .tx_ready(tx_ready),
    .byte_request(byte_request), .read_done(read_done),
    .rom_we(rom_we), .rom_addr(rom_addr), .rom_wdata(rom_wdata),
    .tx_valid(tx_valid), .tx_byte(tx_byte)
  );

  boot_rom rom0 (
    .CLK(CLK), .we(rom_we), .addr(rom_addr), .wdata(rom_wdata), .rdata(rom_rdata)
  );

  uart_tx uart0 (
    .CLK(CLK), .rst(rst), .tx_byte(tx_byte), .tx_valid(tx_valid),
    .tx_ready(tx_ready), .tx(tx)
  );

endmodule

// ==== source/spi_flash_reader.sv ====
`timescale 1ns/1ns
`include "flash_boot_consts.svh"

module spi_flash_reader (
  input  logic       CLK,
  input  logic       rst,
  input  logic       flash_miso,
  input  logic       byte_request,
  input  logic       read_done,
  output logic       flash_sck,
  output logic       flash_ssb,
  output logic       flash_mosi,
  output logic       byte_valid,
  output logic [7:0] byte_data
);

  // Phase FSM
  localparam logic [2:0] ST_SELECT = 3'd0;
  localparam logic [2:0] ST_SEND   = 3'd1;
  localparam logic [2:0] ST_STOP   = 3'd2;
  localparam logic [2:0] ST_WAIT   = 3'd3;
  localparam logic [2:0] ST_RECV   = 3'd4;
  localparam logic [2:0] ST_HOLD   = 3'd5;
  localparam logic [2:0] ST_DONE   = 3'd6;

  // Which command the next select carries
  localparam logic [1:0] CMD_RESET_1 = 2'd0;
  localparam logic [1:0] CMD_RESET_2 = 2'd1;
  localparam logic [1:0] CMD_READ    = 2'd2;

  logic [2:0]  state;
  logic [1:0]  cmd_sel;
  logic        sck_run;
  logic [7:0]  div_cnt;
  logic        sck_tick;
  logic        sck_rise;
  logic        sck_fall;
  logic [4:0]  bit_cnt;
  logic [4:0]  last_bit;
  logic [15:0] wait_cnt;
  logic [15:0] wait_limit;
  logic [31:0] cmd_word;
  logic [31:0] out_shift;

  ////////////////////////////////////////////////////////////
  // SCK divider
  ////////////////////////////////////////////////////////////

  assign sck_tick = sck_run && (div_cnt == 8'(`FLASH_SCK_HALF - 1));

  // Strobes lag the SCK edge by one cycle
  // so MISO has settled when it is sampled
  always_ff @(posedge CLK) begin
    if (rst) begin
      flash_sck <= 1'b0;
      div_cnt   <= 8'd0;
      sck_rise  <= 1'b0;
      sck_fall  <= 1'b0;
    end else begin
      sck_rise <= sck_tick && !flash_sck;
      sck_fall <= sck_tick && flash_sck;
      if (!sck_run) begin
        // Parked low while stopped
        flash_sck <= 1'b0;
        div_cnt   <= 8'd0;
      end else if (sck_tick) begin
        div_cnt   <= 8'd0;
        flash_sck <= ~flash_sck;
      end else begin
        div_cnt <= div_cnt + 8'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Command selection
  ////////////////////////////////////////////////////////////

  // Reset opcodes are 8 bits, read is opcode plus address
  always_comb begin
    case (cmd_sel)
      CMD_RESET_1: cmd_word = {`FLASH_RESET_CMD_1, 24'h000000};
      CMD_RESET_2: cmd_word = {`FLASH_RESET_CMD_2, 24'h000000};
      default:     cmd_word = {`FLASH_READ_CMD, `FLASH_READ_OFFSET};
    endcase
  end

  assign last_bit = (cmd_sel == CMD_READ) ? 5'd31 : 5'd7;
  // Short gap between resets, long recovery before the read
  assign wait_limit = (cmd_sel == CMD_READ) ? 16'(`FLASH_RESET_WAIT - 1)
                                            : 16'(`FLASH_SCK_HALF - 1);

  // Outgoing and incoming shift registers
  always_ff @(posedge CLK) begin
    if (state == ST_SELECT) begin
      out_shift <= cmd_word;
    end else if (state == ST_SEND && sck_fall) begin
      out_shift <= {out_shift[30:0], 1'b0};
    end
    // MSB first
    if (state == ST_RECV && sck_fall) begin
      byte_data <= {byte_data[6:0], flash_miso};
    end
  end

  ////////////////////////////////////////////////////////////
  // Phase FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      state      <= ST_SELECT;
      cmd_sel    <= CMD_RESET_1;
      sck_run    <= 1'b0;
      flash_ssb  <= 1'b1;
      flash_mosi <= 1'b0;
      byte_valid <= 1'b0;
      bit_cnt    <= 5'd0;
      wait_cnt   <= 16'd0;
    end else begin
      byte_valid <= 1'b0;
      case (state)
        ST_SELECT: begin
          // Select and preload the first MOSI bit
          flash_ssb  <= 1'b0;
          flash_mosi <= cmd_word[31];
          bit_cnt    <= 5'd0;
          sck_run    <= 1'b1;
          state      <= ST_SEND;
        end
        ST_SEND: begin
          // Next bit goes out on the falling edge
          if (sck_fall) begin
            flash_mosi <= out_shift[30];
          end
          // Flash has taken a bit on each rising edge
          if (sck_rise) begin
            if (bit_cnt == last_bit) begin
              bit_cnt    <= 5'd0;
              flash_mosi <= 1'b0;
              state      <= (cmd_sel == CMD_READ) ? ST_RECV : ST_STOP;
            end else begin
              bit_cnt <= bit_cnt + 5'd1;
            end
          end
        end
        ST_STOP: begin
          // Let SCK fall before deselecting
          if (sck_fall) begin
            sck_run   <= 1'b0;
            flash_ssb <= 1'b1;
            cmd_sel   <= cmd_sel + 2'd1;
            wait_cnt  <= 16'd0;
            state     <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (wait_cnt == wait_limit) begin
            state <= ST_SELECT;
          end else begin
            wait_cnt <= wait_cnt + 16'd1;
          end
        end
        ST_RECV: begin
          if (sck_fall) begin
            if (bit_cnt == 5'd7) begin
              // Byte complete, stop SCK until asked again
              bit_cnt    <= 5'd0;
              sck_run    <= 1'b0;
              byte_valid <= 1'b1;
              state      <= ST_HOLD;
            end else begin
              bit_cnt <= bit_cnt + 5'd1;
            end
          end
        end
        ST_HOLD: begin
          if (read_done) begin
            flash_ssb <= 1'b1;
            state     <= ST_DONE;
          end else if (byte_request) begin
            sck_run <= 1'b1;
            state   <= ST_RECV;
          end
        end
        ST_DONE: begin
          // Transaction over until reset
          flash_ssb <= 1'b1;
        end
        default: state <= ST_DONE;
      endcase
    end
  end

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ns
`include "flash_boot_consts.svh"

module uart_tx (
  input  logic       CLK,
  input  logic       rst,
  input  logic [7:0] tx_byte,
  input  logic       tx_valid,
  output logic       tx_ready,
  output logic       tx
);

  localparam int CLKS    = `UART_CLKS_PER_BIT;
  localparam int CNT_W   = $clog2(CLKS);
  localparam int FRAME_W = 10;

  logic               busy;
  logic [3:0]         bit_cnt;
  logic [CNT_W-1:0]   baud_cnt;
  logic               bit_end;
  // Stop, data LSB first, start in bit 0
  logic [FRAME_W-1:0] frame;

  assign bit_end  = (baud_cnt == CNT_W'(CLKS - 1));
  assign tx_ready = ~busy;
  // Idle frame is all ones, so the line rests high
  assign tx       = frame[0];

  ////////////////////////////////////////////////////////////
  // 8N1 framer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      busy     <= 1'b0;
      bit_cnt  <= 4'd0;
      baud_cnt <= '0;
      frame    <= '1;
    end else if (!busy) begin
      baud_cnt <= '0;
      bit_cnt  <= 4'd0;
      // Accept on valid while idle
      if (tx_valid) begin
        frame <= {1'b1, tx_byte, 1'b0};
        busy  <= 1'b1;
      end
    end else if (bit_end) begin
      baud_cnt <= '0;
      // Shift in ones behind the frame
      frame    <= {1'b1, frame[FRAME_W-1:1]};
      if (bit_cnt == 4'(FRAME_W - 1)) begin
        // Stop bit finished
        busy <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

// ==== testbench/flash_boot_properties.sv ====
`timescale 1ns/1ns

module flash_boot_properties (
  input logic CLK,
  input logic rst,
  input logic flash_sck,
  input logic flash_ssb,
  input logic flash_wp_n,
  input logic flash_hold_n,
  input logic tx
);

  // SCK parked low while deselected
  sck_idle_low: assert property (@(posedge CLK) disable iff (rst)
    flash_ssb |-> !flash_sck)
    else $error("flash_sck high while flash_ssb is high");

  // Sampled mid-cycle, after the first reset edge has taken effect
  tx_high_in_reset: assert property (@(negedge CLK) rst |-> tx)
    else $error("tx low during reset");

  // Write protect and hold never asserted
  flash_pins_high: assert property (@(posedge CLK) flash_wp_n && flash_hold_n)
    else $error("flash_wp_n or flash_hold_n driven low");

endmodule

bind flash_boot_top flash_boot_properties props0 (
  .CLK(CLK), .rst(rst), .flash_sck(flash_sck), .flash_ssb(flash_ssb),
  .flash_wp_n(flash_wp_n), .flash_hold_n(flash_hold_n), .tx(tx)
);

// ==== testbench/flash_boot_tb.sv ====
`timescale 1ns/1ns
`include "flash_boot_consts.svh"

module flash_boot_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  localparam int TX_BYTES     = 2 * `BOOT_WORDS;
  localparam int CLKS_BIT     = `UART_CLKS_PER_BIT;
  // Worst case for flash load plus serial dump, with margin
  localparam int WATCHDOG_CYCLES = (2 * `BOOT_WORDS * 10 * `UART_CLKS_PER_BIT
    + (2 * `BOOT_WORDS + 6) * 16 * `FLASH_SCK_HALF + `FLASH_RESET_WAIT + 200) * 2;

  logic CLK;
  logic rst;
  logic flash_miso;
  logic flash_sck;
  logic flash_ssb;
  logic flash_mosi;
  logic flash_wp_n;
  logic flash_hold_n;
  logic tx;

  // Flash contents, word 0 sits at the read offset
  logic [15:0] trace [0:`BOOT_WORDS-1];
  int          win_cnt;
  int          rx_count;
  integer      seed;
  int          idle_cycles;

  flash_boot_top dut0 (
    .CLK(CLK), .rst(rst), .flash_miso(flash_miso),
    .flash_sck(flash_sck), .flash_ssb(flash_ssb), .flash_mosi(flash_mosi),
    .flash_wp_n(flash_wp_n), .flash_hold_n(flash_hold_n), .tx(tx)
  );

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "value check failed");
    end
  endtask

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // SPI flash model
  ////////////////////////////////////////////////////////////

  // Edges of SCK are seen on the falling CLK edge, MISO changes there too
  initial begin : flash_model
    logic        sck_prev;
    logic        selected;
    logic        read_mode;
    logic [31:0] rx_shift;
    int          bit_cnt;
    int          rd_bit;
    flash_miso = 1'b0;
    sck_prev   = 1'b0;
    selected   = 1'b0;
    read_mode  = 1'b0;
    rx_shift   = '0;
    bit_cnt    = 0;
    rd_bit     = 0;
    win_cnt    = 0;
    forever begin
      @(negedge CLK);
      if (!rst && flash_ssb) begin
        // Each reset window holds a single opcode
        if (selected && win_cnt <= 2) begin
          expect_equal("reset window bit count", 32'd8, bit_cnt);
        end
        selected  = 1'b0;
        read_mode = 1'b0;
      end else if (!rst) begin
        if (!selected) begin
          selected = 1'b1;
          win_cnt  = win_cnt + 1;
          bit_cnt  = 0;
        end
        if (flash_sck && !sck_prev && !read_mode) begin
          rx_shift = {rx_shift[30:0], flash_mosi};
          bit_cnt  = bit_cnt + 1;
          if (bit_cnt == 8) begin
            case (win_cnt)
              1: expect_equal("reset command 1", `FLASH_RESET_CMD_1, rx_shift[7:0]);
              2: expect_equal("reset command 2", `FLASH_RESET_CMD_2, rx_shift[7:0]);
              default: expect_equal("read command", `FLASH_READ_CMD, rx_shift[7:0]);
            endcase
          end
          if (win_cnt == 3 && bit_cnt == 32) begin
            expect_equal("read address", `FLASH_READ_OFFSET, rx_shift[23:0]);
            read_mode = 1'b1;
          end
        end else if (!flash_sck && sck_prev && read_mode) begin
          // Big-endian words, MSB first
          if (rd_bit < 16 * `BOOT_WORDS) begin
            flash_miso = trace[rd_bit / 16][15 - (rd_bit % 16)];
          end else begin
            flash_miso = 1'b0;
          end
          rd_bit = rd_bit + 1;
        end
      end
      sck_prev = flash_sck;
    end
  end

  ////////////////////////////////////////////////////////////
  // UART decoder
  ////////////////////////////////////////////////////////////

  initial begin : uart_decoder
    logic [7:0]  rx_byte;
    logic [15:0] word;
    rx_count = 0;
    while (rx_count < TX_BYTES) begin
      @(negedge CLK);
      if (!rst && !tx) begin
        // Move to mid start bit
        repeat (CLKS_BIT / 2) @(negedge CLK);
        expect_equal("uart start bit", 32'd0, tx);
        for (int k = 0; k < 8; k++) begin
          repeat (CLKS_BIT) @(negedge CLK);
          rx_byte[k] = tx;
        end
        repeat (CLKS_BIT) @(negedge CLK);
        expect_equal("uart stop bit", 32'd1, tx);
        word = trace[rx_count / 2];
        // High byte first
        expect_equal($sformatf("uart byte %0d", rx_count),
                     (rx_count % 2 == 0) ? word[15:8] : word[7:0], rx_byte);
        rx_count = rx_count + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    rst  = 1'b1;
    seed = 84065;
    $readmemh("testbench/flash_boot_trace.hex", trace);
    repeat (RESET_CYCLES) @(negedge CLK);
    expect_equal("reset flash_ssb", 32'd1, flash_ssb);
    expect_equal("reset tx", 32'd1, tx);
    expect_equal("reset flash_sck", 32'd0, flash_sck);
    expect_equal("reset flash_wp_n", 32'd1, flash_wp_n);
    expect_equal("reset flash_hold_n", 32'd1, flash_hold_n);
    rst = 1'b0;
    wait (rx_count == TX_BYTES);
    idle_cycles = 50 + ($unsigned($random(seed)) % 200);
    // Line and flash select stay quiet after the dump
    repeat (idle_cycles) begin
      @(negedge CLK);
      expect_equal("idle tx", 32'd1, tx);
      expect_equal("idle flash_ssb", 32'd1, flash_ssb);
      expect_equal("idle flash_wp_n", 32'd1, flash_wp_n);
      expect_equal("idle flash_hold_n", 32'd1, flash_hold_n);
    end
    expect_equal("select window count", 32'd3, win_cnt);
    $display("All tests passed");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Some tests failed");
    $fatal(1, "watchdog expired before the boot dump finished");
  end

endmodule

// ==== testbench/flash_boot_trace.hex ====
// One 16-bit flash word per line, hex, in flash address order from the read offset
// Each word is stored big-endian in the flash, high byte at the lower address
A55A
1234
BEEF
0F0F
F00D
8001
7FFE
C3C3
0000
FFFF
2468
9ABC
5A5A
DEAD
0102
E1D2
